// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = warp_scheduler_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = Test completed successfully

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
rtl/gpu_cfg_pkg.sv
rtl/warp_types_pkg.sv
rtl/rr_arbiter.sv
rtl/warp_pc_unit.sv
rtl/warp_table.sv
rtl/warp_scheduler_top.sv
testbench/tb_clock_gen.sv
testbench/warp_scheduler_checker.sv
testbench/warp_scheduler_tb.sv

// File: rtl/gpu_cfg_pkg.sv
// Compute unit configuration
// Size constants and the plain vector types built from them
package gpu_cfg_pkg;

    // ####################
    // Sizes
    // ####################

    // Warp slots in the compute unit
    localparam int unsigned NUM_WARPS       = 4;
    // Threads per warp
    localparam int unsigned WARP_WIDTH      = 8;
    localparam int unsigned PC_WIDTH        = 16;
    localparam int unsigned ADDR_WIDTH      = 32;
    // Block index inside a thread group, used for thread id math
    localparam int unsigned TBLOCK_IDX_BITS = 4;
    // Unique block identifier, returned on completion
    localparam int unsigned TBLOCK_ID_BITS  = 4;
    // Warp id width, one bit minimum
    localparam int unsigned WID_WIDTH       = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    // ####################
    // Vector types
    // ####################

    typedef logic [PC_WIDTH-1:0]        pc_t;
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [WID_WIDTH-1:0]       wid_t;
    typedef logic [WARP_WIDTH-1:0]      act_mask_t;
    typedef logic [TBLOCK_IDX_BITS-1:0] tblock_idx_t;
    typedef logic [TBLOCK_ID_BITS-1:0]  tblock_id_t;

endpackage

// File: rtl/rr_arbiter.sv
// Round-robin arbiter with a generic payload
// Pointer moves past the winner only on a valid/ready transfer
module rr_arbiter #(
    parameter int unsigned N = 4,
    parameter type payload_t = logic
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [N-1:0]       req_i,
    input  payload_t [N-1:0]   payload_i,
    input  logic               ready_i,
    output logic               valid_o,
    output payload_t           payload_o,
    output logic [N-1:0]       grant_o
);
    localparam int unsigned PTR_W = (N > 1) ? $clog2(N) : 1;

    // Priority pointer, first position to look at
    logic [PTR_W-1:0] ptr_q;
    // Index of the current winner
    logic [PTR_W-1:0] sel;

    // ####################
    // Selection
    // ####################

    // Scan from the pointer and wrap, first hit wins
    always_comb begin : pick
        int idx;
        valid_o = 1'b0;
        sel     = '0;
        for (int k = 0; k < int'(N); k++) begin
            idx = (int'(ptr_q) + k) % int'(N);
            if (req_i[idx] && !valid_o) begin
                valid_o = 1'b1;
                sel     = PTR_W'(idx);
            end
        end
    end

    // One-hot grant, empty when nobody asks
    always_comb begin
        grant_o      = '0;
        grant_o[sel] = valid_o;
    end

    assign payload_o = payload_i[sel];

    // ####################
    // Pointer
    // ####################

    // Holds under back-pressure so the presented grant stays put
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (valid_o && ready_i) begin
            // Next search starts right after the accepted winner
            ptr_q <= (sel == PTR_W'(N - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

// File: rtl/warp_pc_unit.sv
// Per-warp fetch state
// Holds the PC and active mask and tracks whether the warp waits on decode
module warp_pc_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   init_i,
    input  gpu_cfg_pkg::pc_t       init_pc_i,
    input  gpu_cfg_pkg::act_mask_t init_mask_i,
    input  logic                   fetched_i,
    input  logic                   decoded_i,
    input  gpu_cfg_pkg::pc_t       next_pc_i,
    input  logic                   stop_i,
    output gpu_cfg_pkg::pc_t       pc_o,
    output gpu_cfg_pkg::act_mask_t act_mask_o,
    output logic                   avail_o
);
    import gpu_cfg_pkg::*;

    pc_t       pc_q;
    act_mask_t mask_q;
    // High while the warp may be fetched, low while an instruction is in decode
    logic      avail_q;

    // PC and mask only change on init or decode
    always_ff @(posedge clk_i) begin
        if (init_i) begin
            pc_q   <= init_pc_i;
            mask_q <= init_mask_i;
        end else if (decoded_i && !stop_i) begin
            pc_q <= next_pc_i;
        end
    end

    // Fetch-wait flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            avail_q <= 1'b0;
        end else if (init_i) begin
            avail_q <= 1'b1;
        end else if (decoded_i) begin
            // Stopped warps stay parked until the slot is reused
            avail_q <= !stop_i;
        end else if (fetched_i) begin
            avail_q <= 1'b0;
        end
    end

    assign pc_o       = pc_q;
    assign act_mask_o = mask_q;
    assign avail_o    = avail_q;

endmodule

// File: rtl/warp_scheduler_top.sv
// Warp scheduler top level
// Slot table, per-warp PC units and the fetch and completion arbiters
module warp_scheduler_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Block allocation
    input  logic                                alloc_valid_i,
    input  warp_types_pkg::alloc_req_t          alloc_req_i,
    output logic                                warp_free_o,
    // Decode strobe
    input  logic                                decode_valid_i,
    input  warp_types_pkg::decode_upd_t         decode_upd_i,
    // Instruction buffer drained, per warp
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0]   idle_i,
    // Fetch
    output logic                                fetch_valid_o,
    output warp_types_pkg::fetch_req_t          fetch_req_o,
    input  logic                                fetch_ready_i,
    // Completion
    output logic                                done_valid_o,
    output warp_types_pkg::done_rsp_t           done_rsp_o,
    input  logic                                done_ready_i
);
    import gpu_cfg_pkg::*;
    import warp_types_pkg::*;

    logic [NUM_WARPS-1:0]       init;
    logic [NUM_WARPS-1:0]       avail;
    pc_t [NUM_WARPS-1:0]        pc;
    act_mask_t [NUM_WARPS-1:0]  act_mask;
    logic [NUM_WARPS-1:0]       decoded;

    logic [NUM_WARPS-1:0]       fetch_req_valid;
    fetch_req_t [NUM_WARPS-1:0] fetch_req;
    logic [NUM_WARPS-1:0]       fetch_grant;
    logic [NUM_WARPS-1:0]       fetched;

    logic [NUM_WARPS-1:0]       done_req;
    done_rsp_t [NUM_WARPS-1:0]  done_payload;
    logic [NUM_WARPS-1:0]       done_grant;
    logic [NUM_WARPS-1:0]       release_w;

    // Grants only count once the consumer takes them
    assign fetched   = fetch_grant & {NUM_WARPS{fetch_ready_i}};
    assign release_w = done_grant & {NUM_WARPS{done_ready_i}};

    warp_table u_table (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .alloc_valid_i     (alloc_valid_i),
        .alloc_req_i       (alloc_req_i),
        .warp_free_o       (warp_free_o),
        .decode_valid_i    (decode_valid_i),
        .decode_upd_i      (decode_upd_i),
        .idle_i            (idle_i),
        .avail_i           (avail),
        .pc_i              (pc),
        .act_mask_i        (act_mask),
        .release_i         (release_w),
        .init_o            (init),
        .fetch_req_o       (fetch_req),
        .fetch_req_valid_o (fetch_req_valid),
        .done_req_o        (done_req),
        .done_payload_o    (done_payload)
    );

    // ####################
    // Per-warp PC units
    // ####################

    for (genvar w = 0; w < NUM_WARPS; w++) begin : gen_pc
        // Decode report addressed to this warp
        assign decoded[w] = decode_valid_i && (decode_upd_i.wid == wid_t'(w));

        warp_pc_unit u_pc (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .init_i      (init[w]),
            .init_pc_i   (alloc_req_i.pc),
            .init_mask_i (alloc_req_i.act_mask),
            .fetched_i   (fetched[w]),
            .decoded_i   (decoded[w]),
            .next_pc_i   (decode_upd_i.next_pc),
            .stop_i      (decode_upd_i.stop),
            .pc_o        (pc[w]),
            .act_mask_o  (act_mask[w]),
            .avail_o     (avail[w])
        );
    end

    // ####################
    // Arbiters
    // ####################

    rr_arbiter #(
        .N         (NUM_WARPS),
        .payload_t (fetch_req_t)
    ) u_fetch_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (fetch_req_valid),
        .payload_i (fetch_req),
        .ready_i   (fetch_ready_i),
        .valid_o   (fetch_valid_o),
        .payload_o (fetch_req_o),
        .grant_o   (fetch_grant)
    );

    rr_arbiter #(
        .N         (NUM_WARPS),
        .payload_t (done_rsp_t)
    ) u_done_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (done_req),
        .payload_i (done_payload),
        .ready_i   (done_ready_i),
        .valid_o   (done_valid_o),
        .payload_o (done_rsp_o),
        .grant_o   (done_grant)
    );

endmodule

// File: rtl/warp_table.sv
// Warp slot table
// Allocates free slots, stores per-warp context, builds fetch and completion requests
module warp_table (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic                                                alloc_valid_i,
    input  warp_types_pkg::alloc_req_t                          alloc_req_i,
    output logic                                                warp_free_o,
    input  logic                                                decode_valid_i,
    input  warp_types_pkg::decode_upd_t                         decode_upd_i,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   idle_i,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   avail_i,
    input  gpu_cfg_pkg::pc_t [gpu_cfg_pkg::NUM_WARPS-1:0]       pc_i,
    input  gpu_cfg_pkg::act_mask_t [gpu_cfg_pkg::NUM_WARPS-1:0] act_mask_i,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   release_i,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   init_o,
    output warp_types_pkg::fetch_req_t [gpu_cfg_pkg::NUM_WARPS-1:0] fetch_req_o,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   fetch_req_valid_o,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0]                   done_req_o,
    output warp_types_pkg::done_rsp_t [gpu_cfg_pkg::NUM_WARPS-1:0] done_payload_o
);
    import gpu_cfg_pkg::*;
    import warp_types_pkg::*;

    warp_ctx_t [NUM_WARPS-1:0] ctx_q;
    warp_ctx_t [NUM_WARPS-1:0] ctx_d;

    // Lowest free slot, one-hot
    logic [NUM_WARPS-1:0] alloc_oh;
    logic                 alloc_take;

    // ####################
    // Allocation
    // ####################

    always_comb begin : find_free
        logic found;
        found    = 1'b0;
        alloc_oh = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (!ctx_q[i].occupied && !found) begin
                alloc_oh[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    // At least one slot left
    assign warp_free_o = (alloc_oh != '0);
    assign alloc_take  = alloc_valid_i && warp_free_o;
    // Starts the matching pc unit in the same cycle the slot is claimed
    assign init_o      = alloc_take ? alloc_oh : '0;

    // ####################
    // Context update
    // ####################

    always_comb begin
        ctx_d = ctx_q;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (alloc_take && alloc_oh[i]) begin
                ctx_d[i].occupied   = 1'b1;
                ctx_d[i].finished   = 1'b0;
                ctx_d[i].dp_addr    = alloc_req_i.dp_addr;
                ctx_d[i].tblock_idx = alloc_req_i.tblock_idx;
                ctx_d[i].tblock_id  = alloc_req_i.tblock_id;
            end
            // Completion accepted, slot goes back to the pool
            if (release_i[i]) begin
                ctx_d[i].occupied = 1'b0;
                ctx_d[i].finished = 1'b0;
            end
        end
        // Stop from decode, drain before reporting
        if (decode_valid_i && decode_upd_i.stop) begin
            ctx_d[decode_upd_i.wid].finished = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctx_q <= '0;
        end else begin
            ctx_q <= ctx_d;
        end
    end

    // ####################
    // Requests
    // ####################

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            // Running warp with no instruction waiting on decode
            fetch_req_valid_o[i]      = ctx_q[i].occupied && !ctx_q[i].finished
                                        && avail_i[i];
            fetch_req_o[i].wid        = wid_t'(i);
            fetch_req_o[i].pc         = pc_i[i];
            fetch_req_o[i].act_mask   = act_mask_i[i];
            fetch_req_o[i].dp_addr    = ctx_q[i].dp_addr;
            fetch_req_o[i].tblock_idx = ctx_q[i].tblock_idx;

            // Finished and nothing left in the instruction buffer
            done_req_o[i]               = ctx_q[i].occupied && ctx_q[i].finished && idle_i[i];
            done_payload_o[i].tblock_id = ctx_q[i].tblock_id;
            done_payload_o[i].wid       = wid_t'(i);
        end
    end

endmodule

// File: rtl/warp_types_pkg.sv
// Warp scheduler interface structs
// Payloads exchanged between the scheduler blocks and the pipeline around them
package warp_types_pkg;

    // New thread block handed to the compute unit
    typedef struct packed {
        gpu_cfg_pkg::pc_t         pc;
        gpu_cfg_pkg::act_mask_t   act_mask;
        // Data / parameter address
        gpu_cfg_pkg::addr_t       dp_addr;
        gpu_cfg_pkg::tblock_idx_t tblock_idx;
        gpu_cfg_pkg::tblock_id_t  tblock_id;
    } alloc_req_t;

    // Decode stage report for one warp
    typedef struct packed {
        gpu_cfg_pkg::wid_t wid;
        gpu_cfg_pkg::pc_t  next_pc;
        // Last instruction of the warp
        logic              stop;
    } decode_upd_t;

    // Everything the fetcher needs for one warp
    typedef struct packed {
        gpu_cfg_pkg::wid_t        wid;
        gpu_cfg_pkg::pc_t         pc;
        gpu_cfg_pkg::act_mask_t   act_mask;
        gpu_cfg_pkg::addr_t       dp_addr;
        gpu_cfg_pkg::tblock_idx_t tblock_idx;
    } fetch_req_t;

    // Stored context of one warp slot
    typedef struct packed {
        logic                     occupied;
        // Stop seen, waiting for in-flight instructions to drain
        logic                     finished;
        gpu_cfg_pkg::addr_t       dp_addr;
        gpu_cfg_pkg::tblock_idx_t tblock_idx;
        gpu_cfg_pkg::tblock_id_t  tblock_id;
    } warp_ctx_t;

    // Completed thread block report
    typedef struct packed {
        gpu_cfg_pkg::tblock_id_t tblock_id;
        gpu_cfg_pkg::wid_t       wid;
    } done_rsp_t;

endpackage

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset source
// 10 ns clock, active-low reset held for 8 cycles
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: testbench/warp_scheduler_checker.sv
// Warp scheduler port checker
// Concurrent assertions on the top-level handshakes and the slot table
module warp_scheduler_checker (
    input logic                                                  clk_i,
    input logic                                                  rst_n_i,
    input logic                                                  alloc_valid_i,
    input logic                                                  decode_valid_i,
    input logic [gpu_cfg_pkg::NUM_WARPS-1:0]                     idle_i,
    input logic                                                  fetch_valid_i,
    input warp_types_pkg::fetch_req_t                            fetch_req_i,
    input logic                                                  fetch_ready_i,
    input logic                                                  done_valid_i,
    input warp_types_pkg::done_rsp_t                             done_rsp_i,
    input logic                                                  done_ready_i,
    input logic                                                  warp_free_i,
    input warp_types_pkg::warp_ctx_t [gpu_cfg_pkg::NUM_WARPS-1:0] ctx_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import gpu_cfg_pkg::*;

    // Occupied flag of every slot
    logic [NUM_WARPS-1:0] occupied;
    // Slots in use, counted from the allocation and completion handshakes
    logic [WID_WIDTH:0]   used_q;
    logic                 alloc_take;
    logic                 done_take;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            occupied[i] = ctx_i[i].occupied;
        end
    end

    assign alloc_take = alloc_valid_i && warp_free_i;
    assign done_take  = done_valid_i && done_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            used_q <= '0;
        end else if (alloc_take && !done_take) begin
            used_q <= used_q + 1'b1;
        end else if (done_take && !alloc_take) begin
            used_q <= used_q - 1'b1;
        end
    end

    // A warp with no live thread never goes to fetch
    a_fetch_mask : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i |-> fetch_req_i.act_mask != '0)
        else $error("fetch request with an empty active mask");

    // Stalled fetch holds while no new warp state arrives
    a_fetch_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i && !fetch_ready_i && !alloc_valid_i && !decode_valid_i
        |=> fetch_valid_i && $stable(fetch_req_i))
        else $error("stalled fetch request changed or was withdrawn");

    // Stalled completion holds unless the idle levels move
    a_done_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_valid_i && !done_ready_i && !decode_valid_i
        |=> !$stable(idle_i) || (done_valid_i && $stable(done_rsp_i)))
        else $error("stalled completion request changed or was withdrawn");

    // No free slot means every slot has been handed out
    a_free_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !warp_free_i |-> int'(used_q) == NUM_WARPS)
        else $error("warp_free_o low with a slot still empty");

    // Table occupancy follows the port handshakes
    a_occ_count : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $countones(occupied) == int'(used_q))
        else $error("slot table occupancy differs from the handshake count");

endmodule

bind warp_scheduler_top warp_scheduler_checker u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_valid_i  (alloc_valid_i),
    .decode_valid_i (decode_valid_i),
    .idle_i         (idle_i),
    .fetch_valid_i  (fetch_valid_o),
    .fetch_req_i    (fetch_req_o),
    .fetch_ready_i  (fetch_ready_i),
    .done_valid_i   (done_valid_o),
    .done_rsp_i     (done_rsp_o),
    .done_ready_i   (done_ready_i),
    .warp_free_i    (warp_free_o),
    .ctx_i          (u_table.ctx_q)
);

// File: testbench/warp_scheduler_tb.sv
// Warp scheduler testbench
// Directed tests against a slot model for allocation, fetch order, decode and completion
module warp_scheduler_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import gpu_cfg_pkg::*;
    import warp_types_pkg::*;

    localparam int NW           = NUM_WARPS;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    // Cycles the directed tests take after reset, with some slack
    localparam int TEST_CYCLES  = 50;
    localparam int MARGIN_NS    = 200;
    localparam logic [31:0] RAND_SEED = 32'ha978_4165;

    logic        clk;
    logic        rst_n;
    logic        alloc_valid_i;
    alloc_req_t  alloc_req_i;
    logic        warp_free_o;
    logic        decode_valid_i;
    decode_upd_t decode_upd_i;
    logic [NW-1:0] idle_i;
    logic        fetch_valid_o;
    fetch_req_t  fetch_req_o;
    logic        fetch_ready_i;
    logic        done_valid_o;
    done_rsp_t   done_rsp_o;
    logic        done_ready_i;

    // ####################
    // Slot model
    // ####################

    logic        m_occ   [NW];
    logic        m_fin   [NW];
    // Warp may be fetched, cleared by a fetch and set again by decode
    logic        m_avail [NW];
    pc_t         m_pc    [NW];
    act_mask_t   m_mask  [NW];
    addr_t       m_addr  [NW];
    tblock_idx_t m_idx   [NW];
    tblock_id_t  m_id    [NW];
    // First slot the fetch arbiter looks at
    int          m_ptr;

    int errors;
    int checks;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    warp_scheduler_top UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .alloc_valid_i  (alloc_valid_i),
        .alloc_req_i    (alloc_req_i),
        .warp_free_o    (warp_free_o),
        .decode_valid_i (decode_valid_i),
        .decode_upd_i   (decode_upd_i),
        .idle_i         (idle_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_req_o    (fetch_req_o),
        .fetch_ready_i  (fetch_ready_i),
        .done_valid_o   (done_valid_o),
        .done_rsp_o     (done_rsp_o),
        .done_ready_i   (done_ready_i)
    );

    // Expected fetch payload of one slot
    function automatic fetch_req_t model_fetch(int w);
        fetch_req_t r;
        r.wid        = wid_t'(w);
        r.pc         = m_pc[w];
        r.act_mask   = m_mask[w];
        r.dp_addr    = m_addr[w];
        r.tblock_idx = m_idx[w];
        return r;
    endfunction

    // Eligible warp at or after the pointer, -1 when none
    function automatic int model_next_fetch();
        int w;
        for (int k = 0; k < NW; k++) begin
            w = (m_ptr + k) % NW;
            if (m_occ[w] && !m_fin[w] && m_avail[w]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Lowest empty slot, -1 when the table is full
    function automatic int model_free_slot();
        for (int w = 0; w < NW; w++) begin
            if (!m_occ[w]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // ####################
    // Timing and compares
    // ####################

    // Drive point, just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Sample point, mid cycle
    task automatic settle();
        @(negedge clk);
    endtask

    task automatic check_fetch(fetch_req_t got, fetch_req_t exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_done(done_rsp_t got, done_rsp_t exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_free(logic got, logic exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // Valid flags of the fetch and completion ports
    task automatic check_valid(logic got, logic exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // ####################
    // Stimulus
    // ####################

    // Offer one random block for a cycle, the model places it in the lowest free slot
    task automatic alloc_block();
        alloc_req_t req;
        int         slot;
        req.pc         = pc_t'($urandom());
        req.act_mask   = act_mask_t'($urandom());
        req.dp_addr    = addr_t'($urandom());
        req.tblock_idx = tblock_idx_t'($urandom());
        req.tblock_id  = tblock_id_t'($urandom());
        // Keep at least one live thread
        if (req.act_mask == '0) begin
            req.act_mask = '1;
        end
        slot           = model_free_slot();
        alloc_req_i    = req;
        alloc_valid_i  = 1'b1;
        settle();
        check_free(warp_free_o, slot >= 0, "warp_free_o while offering a block");
        tick();
        alloc_valid_i = 1'b0;
        if (slot >= 0) begin
            m_occ[slot]   = 1'b1;
            m_fin[slot]   = 1'b0;
            m_avail[slot] = 1'b1;
            m_pc[slot]    = req.pc;
            m_mask[slot]  = req.act_mask;
            m_addr[slot]  = req.dp_addr;
            m_idx[slot]   = req.tblock_idx;
            m_id[slot]    = req.tblock_id;
        end
    endtask

    // One-cycle decode strobe with a random next PC
    task automatic decode_warp(int w, logic stop);
        decode_upd_t upd;
        upd.wid        = wid_t'(w);
        upd.next_pc    = pc_t'($urandom());
        upd.stop       = stop;
        decode_upd_i   = upd;
        decode_valid_i = 1'b1;
        tick();
        decode_valid_i = 1'b0;
        m_avail[w] = !stop;
        if (stop) begin
            m_fin[w] = 1'b1;
        end else begin
            m_pc[w] = upd.next_pc;
        end
    endtask

    // Fetch ready held high, every transfer checked against round-robin order
    task automatic fetch_round(int n);
        int w;
        fetch_ready_i = 1'b1;
        for (int i = 0; i < n; i++) begin
            settle();
            w = model_next_fetch();
            check_valid(fetch_valid_o, w >= 0, "fetch_valid_o in a fetch round");
            if (w >= 0) begin
                check_fetch(fetch_req_o, model_fetch(w), "fetch_req_o in round-robin order");
                m_avail[w] = 1'b0;
                m_ptr      = (w + 1) % NW;
            end
            tick();
        end
        fetch_ready_i = 1'b0;
    endtask

    // Polls for a completion request, ends on a drive point
    task automatic wait_done(int limit);
        int n;
        n = 0;
        settle();
        while (!done_valid_o && n < limit) begin
            tick();
            settle();
            n++;
        end
        if (!done_valid_o) begin
            errors++;
            $display("Completion request did not appear within %0d cycles", limit);
        end
        tick();
    endtask

    // ####################
    // Directed tests
    // ####################

    task automatic test_reset();
        settle();
        check_free(warp_free_o, 1'b1, "warp_free_o after reset");
        check_valid(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
        check_valid(done_valid_o, 1'b0, "done_valid_o after reset");
        tick();
    endtask

    // Fill every slot, then one more block that must be dropped
    task automatic test_alloc();
        for (int i = 0; i <= NW; i++) begin
            alloc_block();
        end
        settle();
        check_free(warp_free_o, 1'b0, "warp_free_o with a full table");
        check_valid(fetch_valid_o, 1'b1, "fetch_valid_o after allocation");
        check_fetch(fetch_req_o, model_fetch(model_next_fetch()), "fetch_req_o after allocation");
        tick();
    endtask

    task automatic test_fairness();
        fetch_round(NW);
        // Every warp now waits on decode
        settle();
        check_valid(fetch_valid_o, 1'b0, "fetch_valid_o with all warps waiting on decode");
        tick();
    endtask

    task automatic test_decode();
        fetch_req_t held;
        for (int w = 0; w < NW; w++) begin
            decode_warp(w, 1'b0);
        end
        held = model_fetch(model_next_fetch());
        // Back-pressure from the fetcher
        for (int i = 0; i < 3; i++) begin
            settle();
            check_valid(fetch_valid_o, 1'b1, "fetch_valid_o while fetch_ready_i is low");
            check_fetch(fetch_req_o, held, "fetch_req_o while fetch_ready_i is low");
            tick();
        end
        fetch_round(NW);
    endtask

    task automatic test_completion();
        int        w;
        done_rsp_t exp;
        w = 1;
        decode_warp(w, 1'b1);
        settle();
        check_valid(done_valid_o, 1'b0, "done_valid_o before the warp is idle");
        tick();
        idle_i[w]     = 1'b1;
        exp.tblock_id = m_id[w];
        exp.wid       = wid_t'(w);
        wait_done(4);
        for (int i = 0; i < 3; i++) begin
            settle();
            check_valid(done_valid_o, 1'b1, "done_valid_o while done_ready_i is low");
            check_done(done_rsp_o, exp, "done_rsp_o while done_ready_i is low");
            tick();
        end
        done_ready_i = 1'b1;
        settle();
        check_done(done_rsp_o, exp, "done_rsp_o at acceptance");
        tick();
        done_ready_i = 1'b0;
        idle_i[w]    = 1'b0;
        m_occ[w]     = 1'b0;
        m_fin[w]     = 1'b0;
        settle();
        check_free(warp_free_o, 1'b1, "warp_free_o after completion");
        check_valid(done_valid_o, 1'b0, "done_valid_o after completion");
        tick();
        // Freed slot is the lowest one and takes the next block
        alloc_block();
        settle();
        check_free(warp_free_o, 1'b0, "warp_free_o after slot reuse");
        check_fetch(fetch_req_o, model_fetch(model_next_fetch()), "fetch_req_o of the reused slot");
        tick();
    endtask

    // ####################
    // Run control
    // ####################

    initial begin : main
        alloc_valid_i  = 1'b0;
        alloc_req_i    = '0;
        decode_valid_i = 1'b0;
        decode_upd_i   = '0;
        idle_i         = '0;
        fetch_ready_i  = 1'b0;
        done_ready_i   = 1'b0;
        errors         = 0;
        checks         = 0;
        m_ptr          = 0;
        for (int w = 0; w < NW; w++) begin
            m_occ[w]   = 1'b0;
            m_fin[w]   = 1'b0;
            m_avail[w] = 1'b0;
        end
        void'($urandom(RAND_SEED));
        @(posedge rst_n);
        tick();
        test_reset();
        test_alloc();
        test_fairness();
        test_decode();
        test_completion();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Stops a hung run
    initial begin : watchdog
        #((RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + MARGIN_NS);
        $display("Timeout: the directed tests did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule
